//--- rtl/hdc_cfg.svh
`ifndef HDC_CFG_SVH
`define HDC_CFG_SVH

// hypervector and word geometry
`define HDC_DIM     128
`define HDC_WORD_W  32
`define HDC_WORDS   (`HDC_DIM / `HDC_WORD_W)

// item memory depth
`define HDC_ITEMS   16

// instruction layout, opcode on top, operand in the low bits
`define HDC_INST_W  16
`define HDC_OP_MSB  15
`define HDC_OP_LSB  13
`define HDC_ARG_W   7

`endif

//--- rtl/hdc_pkg.sv
`include "hdc_cfg.svh"

package hdc_pkg;

    typedef logic [`HDC_DIM-1:0]               hv_t;
    typedef logic [`HDC_WORD_W-1:0]            word_t;
    typedef logic [$clog2(`HDC_ITEMS)-1:0]     item_addr_t;
    typedef logic [$clog2(`HDC_WORDS)-1:0]     slot_t;
    typedef logic [`HDC_ARG_W-1:0]             rot_t;
    typedef logic [`HDC_INST_W-1:0]            inst_t;

    // opcode field, code 7 is decoded as a nop
    typedef enum logic [2:0] {
        OP_NOP    = 3'd0,
        OP_LOAD   = 3'd1,
        OP_ROTATE = 3'd2,
        OP_BIND   = 3'd3,
        OP_SAVE   = 3'd4,
        OP_STORE  = 3'd5,
        OP_LAST   = 3'd6
    } op_e;

    // item fill mode
    typedef enum logic [1:0] {
        MODE_IDLE = 2'd0,
        MODE_GEN  = 2'd1,
        MODE_COM  = 2'd2
    } mode_e;

endpackage

//--- rtl/hdc_fill_if.sv
interface hdc_fill_if;
    import hdc_pkg::*;

    slot_t slot;
    logic  capture;
    logic  use_prng;
    logic  clear;

    modport ctrl (
        output slot,
        output capture,
        output use_prng,
        output clear
    );

    modport builder (
        input slot,
        input capture,
        input use_prng,
        input clear
    );

endinterface

//--- rtl/hdc_core_ctrl.sv
`include "hdc_cfg.svh"

module hdc_core_ctrl (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                run,
    input  logic                gen,
    input  logic                com,
    input  logic                word_valid,
    input  hdc_pkg::item_addr_t item_count,
    input  logic                inst_valid,
    input  hdc_pkg::inst_t      inst,
    hdc_fill_if.ctrl            fill,
    output logic                mem_wr_en,
    output hdc_pkg::item_addr_t mem_wr_addr,
    output logic                gen_done,
    output logic                op_valid,
    output hdc_pkg::op_e        op,
    output hdc_pkg::rot_t       rot
);
    import hdc_pkg::*;

    mode_e      mode;
    mode_e      mode_next;
    slot_t      slot_cnt;
    logic       accept;
    logic       line_full;
    logic [2:0] op_field;
    op_e        op_dec;

    // a mode holds until its own level drops
    always_comb begin
        mode_next = mode;
        case (mode)
            MODE_IDLE: begin
                if (gen) begin
                    mode_next = MODE_GEN;
                end else if (com) begin
                    mode_next = MODE_COM;
                end
            end
            MODE_GEN: begin
                if (!gen) begin
                    mode_next = com ? MODE_COM : MODE_IDLE;
                end
            end
            MODE_COM: begin
                if (!com) begin
                    mode_next = gen ? MODE_GEN : MODE_IDLE;
                end
            end
            default: mode_next = MODE_IDLE;
        endcase
    end

    // generator gives a word every cycle, host only on its strobe
    assign accept = (mode_next == MODE_GEN) || (mode_next == MODE_COM && word_valid);
    assign line_full = accept && (slot_cnt == slot_t'(`HDC_WORDS - 1));

    assign fill.slot     = slot_cnt;
    assign fill.capture  = accept;
    assign fill.use_prng = (mode_next == MODE_GEN);
    assign fill.clear    = (mode_next == MODE_IDLE);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mode        <= MODE_IDLE;
            slot_cnt    <= '0;
            mem_wr_en   <= 1'b0;
            mem_wr_addr <= '0;
        end else begin
            mode <= mode_next;
            if (mode_next == MODE_IDLE) begin
                slot_cnt    <= '0;
                mem_wr_en   <= 1'b0;
                mem_wr_addr <= '0;
            end else begin
                // line write lands one cycle after the last slot
                mem_wr_en <= line_full;
                if (accept) begin
                    slot_cnt <= slot_cnt + 1'b1;
                end
                if (mem_wr_en) begin
                    mem_wr_addr <= mem_wr_addr + 1'b1;
                end
            end
        end
    end

    assign gen_done = mem_wr_en && (mem_wr_addr == item_count);

    // unused opcode codes fall back to nop
    assign op_field = inst[`HDC_OP_MSB:`HDC_OP_LSB];
    assign op_dec   = (op_field > 3'(OP_LAST)) ? OP_NOP : op_e'(op_field);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op_valid <= 1'b0;
            op       <= OP_NOP;
            rot      <= '0;
        end else if (!run) begin
            op_valid <= 1'b0;
            op       <= OP_NOP;
            rot      <= '0;
        end else begin
            op_valid <= inst_valid;
            op       <= op_dec;
            rot      <= inst[`HDC_ARG_W-1:0];
        end
    end

endmodule

//--- rtl/xorshift_prng.sv
module xorshift_prng (
    input  logic           clk,
    input  logic           arst_n,
    input  logic           step,
    input  logic           reseed,
    output hdc_pkg::word_t word
);
    import hdc_pkg::*;

    localparam word_t SEED = 32'h0246_3534;

    word_t state;
    word_t s1;
    word_t s2;
    word_t s3;

    // xorshift32, shifts 13 / 17 / 5
    assign s1 = state ^ (state << 13);
    assign s2 = s1 ^ (s1 >> 17);
    assign s3 = s2 ^ (s2 << 5);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= SEED;
        end else if (reseed) begin
            state <= SEED;
        end else if (step) begin
            state <= s3;
        end
    end

    assign word = state;

endmodule

//--- rtl/item_line_builder.sv
`include "hdc_cfg.svh"

module item_line_builder (
    input  logic           clk,
    input  logic           arst_n,
    input  hdc_pkg::word_t prng_word,
    input  hdc_pkg::word_t host_word,
    hdc_fill_if.builder    fill,
    output hdc_pkg::hv_t   line
);
    import hdc_pkg::*;

    word_t sel_word;

    assign sel_word = fill.use_prng ? prng_word : host_word;

    // slot 0 holds the lowest word of the line
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            line <= '0;
        end else if (fill.clear) begin
            line <= '0;
        end else if (fill.capture) begin
            line[fill.slot * `HDC_WORD_W +: `HDC_WORD_W] <= sel_word;
        end
    end

endmodule

//--- rtl/item_memory.sv
`include "hdc_cfg.svh"

module item_memory (
    input  logic                clk,
    input  logic                wr_en,
    input  hdc_pkg::item_addr_t wr_addr,
    input  hdc_pkg::hv_t        wr_line,
    input  hdc_pkg::item_addr_t rd_addr,
    output hdc_pkg::hv_t        rd_line
);
    import hdc_pkg::*;

    hv_t mem [`HDC_ITEMS];

    // read every cycle, old data on a same-address write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_line;
        end
        rd_line <= mem[rd_addr];
    end

endmodule

//--- rtl/hv_alu.sv
`include "hdc_cfg.svh"

module hv_alu (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          run,
    input  logic          op_valid,
    input  hdc_pkg::op_e  op,
    input  hdc_pkg::rot_t rot,
    input  hdc_pkg::hv_t  item_line,
    output logic          store,
    output hdc_pkg::hv_t  result,
    output logic          last
);
    import hdc_pkg::*;

    hv_t                   work_q;
    hv_t                   saved_q;
    hv_t                   rotated;
    hv_t                   stage_buf;
    hv_t                   out_buf;
    logic [2*`HDC_DIM-1:0] rot_dbl;
    logic                  exec;
    logic                  is_store;
    logic                  is_last;
    logic                  stage_store;
    logic                  stage_last;

    assign exec     = op_valid && run;
    assign is_store = exec && (op == OP_STORE);
    assign is_last  = exec && (op == OP_LAST);

    // rotate left, upper half of the doubled vector
    assign rot_dbl = {work_q, work_q} << rot;
    assign rotated = rot_dbl[2*`HDC_DIM-1 -: `HDC_DIM];

    always_ff @(posedge clk) begin
        if (exec) begin
            case (op)
                OP_LOAD:   work_q  <= item_line;
                OP_ROTATE: work_q  <= rotated;
                OP_BIND:   work_q  <= saved_q ^ work_q;
                OP_SAVE:   saved_q <= work_q;
                default: ;
            endcase
        end
    end

    // two stages from execute to the store and last pins
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stage_store <= 1'b0;
            stage_last  <= 1'b0;
            stage_buf   <= '0;
            store       <= 1'b0;
            last        <= 1'b0;
            out_buf     <= '0;
        end else if (!run) begin
            stage_store <= 1'b0;
            stage_last  <= 1'b0;
            stage_buf   <= '0;
            store       <= 1'b0;
            last        <= 1'b0;
            out_buf     <= '0;
        end else begin
            stage_store <= is_store;
            stage_last  <= is_last;
            stage_buf   <= is_store ? work_q : '0;
            store       <= stage_store;
            last        <= stage_last;
            out_buf     <= stage_buf;
        end
    end

    assign result = out_buf;

endmodule

//--- rtl/hdc_core_top.sv
module hdc_core_top (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                run,
    input  logic                gen,
    input  logic                com,
    input  logic                reseed,
    input  hdc_pkg::item_addr_t item_count,
    input  logic                word_valid,
    input  hdc_pkg::word_t      word_in,
    input  logic                inst_valid,
    input  hdc_pkg::inst_t      inst,
    output logic                gen_done,
    output logic                store,
    output hdc_pkg::hv_t        result,
    output logic                last
);
    import hdc_pkg::*;

    word_t      prng_word;
    hv_t        line;
    hv_t        rd_line;
    logic       mem_wr_en;
    item_addr_t mem_wr_addr;
    logic       op_valid;
    op_e        op;
    rot_t       rot;

    hdc_fill_if fill_bus ();

    hdc_core_ctrl u_hdc_core_ctrl (
        .clk         (clk),
        .arst_n      (arst_n),
        .run         (run),
        .gen         (gen),
        .com         (com),
        .word_valid  (word_valid),
        .item_count  (item_count),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .fill        (fill_bus.ctrl),
        .mem_wr_en   (mem_wr_en),
        .mem_wr_addr (mem_wr_addr),
        .gen_done    (gen_done),
        .op_valid    (op_valid),
        .op          (op),
        .rot         (rot)
    );

    xorshift_prng u_xorshift_prng (
        .clk    (clk),
        .arst_n (arst_n),
        .step   (gen),
        .reseed (reseed),
        .word   (prng_word)
    );

    item_line_builder u_item_line_builder (
        .clk       (clk),
        .arst_n    (arst_n),
        .prng_word (prng_word),
        .host_word (word_in),
        .fill      (fill_bus.builder),
        .line      (line)
    );

    // read address straight from the operand so data meets the decoded op
    item_memory u_item_memory (
        .clk     (clk),
        .wr_en   (mem_wr_en),
        .wr_addr (mem_wr_addr),
        .wr_line (line),
        .rd_addr (inst[$bits(item_addr_t)-1:0]),
        .rd_line (rd_line)
    );

    hv_alu u_hv_alu (
        .clk       (clk),
        .arst_n    (arst_n),
        .run       (run),
        .op_valid  (op_valid),
        .op        (op),
        .rot       (rot),
        .item_line (rd_line),
        .store     (store),
        .result    (result),
        .last      (last)
    );

endmodule

//--- tests/hdc_core_properties.sv
module hdc_core_properties (
    input logic                clk,
    input logic                arst_n,
    input logic                store,
    input logic                last,
    input logic                gen_done,
    input logic                mem_wr_en,
    input hdc_pkg::hv_t        result,
    input hdc_pkg::mode_e      mode
);
    timeunit 1ns;
    timeprecision 1ps;

    import hdc_pkg::*;

    // result bus is quiet outside a store pulse
    a_result_zero: assert property (@(posedge clk) disable iff (!arst_n)
        !store |-> (result == '0))
        else $error("result nonzero while store is low");

    a_store_last: assert property (@(posedge clk) disable iff (!arst_n)
        !(store && last))
        else $error("store and last high together");

    // line writes only happen inside a fill mode
    a_wr_mode: assert property (@(posedge clk) disable iff (!arst_n)
        mem_wr_en |-> (mode != MODE_IDLE))
        else $error("item write while idle");

    a_reset_quiet: assert property (@(posedge clk)
        !arst_n |-> (!store && !last && !gen_done))
        else $error("output pulse during reset");

endmodule

bind hdc_core_top hdc_core_properties u_hdc_core_properties (
    .clk       (clk),
    .arst_n    (arst_n),
    .store     (store),
    .last      (last),
    .gen_done  (gen_done),
    .mem_wr_en (mem_wr_en),
    .result    (result),
    .mode      (u_hdc_core_ctrl.mode)
);

//--- tests/hdc_core_tb.sv
`include "hdc_cfg.svh"

module hdc_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] PRNG_SEED = 32'h0246_3534;

    logic clk, arst_n, run, gen, com, reseed, word_valid, inst_valid;
    logic [3:0] item_count;
    logic [31:0] word_in;
    logic [15:0] inst;
    logic gen_done, store, last;
    logic [`HDC_DIM-1:0] result;

    // reference model state
    logic [`HDC_DIM-1:0] m_mem [16];
    logic [`HDC_DIM-1:0] m_work, m_saved, host_line, snap_work, snap_saved;
    logic [31:0] m_prng, lfsr;
    int host_slot, host_addr, exp_last, snap_size, snap_last;
    logic [`HDC_DIM-1:0] exp_q[$];
    logic [`HDC_DIM-1:0] got_q[$];
    int got_last, done_cnt, cycle, limit, test_err, pass_cnt, fail_cnt;
    bit prev_inst;

    hdc_core_top u_hdc_core_top (
        .clk(clk), .arst_n(arst_n), .run(run), .gen(gen), .com(com), .reseed(reseed),
        .item_count(item_count), .word_valid(word_valid), .word_in(word_in),
        .inst_valid(inst_valid), .inst(inst), .gen_done(gen_done), .store(store),
        .result(result), .last(last)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // outputs sampled mid cycle
    initial begin
        forever begin
            @(negedge clk);
            if (store) got_q.push_back(result);
            if (last) got_last++;
            if (gen_done) done_cnt++;
        end
    end

    initial begin
        wait (limit != 0);
        while (cycle < limit) begin
            @(posedge clk);
            cycle++;
        end
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [`HDC_DIM-1:0] rotate_left(input logic [`HDC_DIM-1:0] v,
                                                        input int n);
        logic [`HDC_DIM-1:0] r;
        for (int i = 0; i < `HDC_DIM; i++) begin
            r[(i + n) % `HDC_DIM] = v[i];
        end
        return r;
    endfunction

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic check_value(input logic [8*16-1:0] name, input logic [`HDC_DIM-1:0] exp,
                               input logic [`HDC_DIM-1:0] act);
        if (exp !== act) begin
            $display("mismatch %0s expected %h actual %h", name, exp, act);
            test_err++;
        end
    endtask

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic issue(input logic [15:0] v, input logic [31:0] g);
        int gap;
        gap = 0;
        if (g != 0) begin
            for (int i = 0; i < 2; i++) begin
                gap = (gap << 1) | int'(lfsr[31]);
                lfsr = lfsr_next(lfsr);
            end
        end
        repeat (gap) tick();
        snap_work = m_work;
        snap_saved = m_saved;
        snap_size = exp_q.size();
        snap_last = exp_last;
        case (v[15:13])
            3'd1: m_work = m_mem[v[3:0]];
            3'd2: m_work = rotate_left(m_work, int'(v[6:0]));
            3'd3: m_work = m_saved ^ m_work;
            3'd4: m_saved = m_work;
            3'd5: exp_q.push_back(m_work);
            3'd6: exp_last++;
            default: ;
        endcase
        inst_valid = 1'b1;
        inst = v;
        tick();
        inst_valid = 1'b0;
    endtask

    task automatic finish_test(input logic [8*16-1:0] name, input int lasts);
        int n;
        n = 0;
        while (got_q.size() < exp_q.size() && n < 30) begin
            tick();
            n++;
        end
        if (got_q.size() < exp_q.size()) begin
            $display("%0s: store pulses did not arrive", name);
            test_err++;
        end
        repeat (3) tick();
        check_value(name, exp_q.size(), got_q.size());
        check_value(name, lasts, got_last);
        check_value(name, exp_last, got_last);
        for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            check_value(name, exp_q[i], got_q[i]);
        end
        if (test_err == 0) pass_cnt++;
        else fail_cnt++;
        $display("test %0s finished with %0d errors", name, test_err);
        exp_q.delete();
        got_q.delete();
        got_last = 0;
        exp_last = 0;
        test_err = 0;
    endtask

    initial begin
        int fd, r, nlines;
        logic [8*16-1:0] kw, name;
        logic [8*128-1:0] buf_line;
        logic [31:0] a, b;
        arst_n = 1'b1;
        run = 1'b0;
        gen = 1'b0;
        com = 1'b0;
        reseed = 1'b0;
        item_count = '0;
        word_valid = 1'b0;
        word_in = '0;
        inst_valid = 1'b0;
        inst = '0;
        lfsr = 32'ha037_07f4;
        m_prng = PRNG_SEED;
        m_work = '0;
        m_saved = '0;
        host_line = '0;
        nlines = 0;
        fd = $fopen("tests/hdc_core_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vector file");
            fail_cnt++;
        end else begin
            while (!$feof(fd)) begin
                r = $fgets(buf_line, fd);
                if (r > 0) nlines++;
            end
            $fclose(fd);
        end
        limit = 40 * nlines + 200;
        #1 arst_n = 1'b0;
        repeat (2) @(posedge clk);
        #2 arst_n = 1'b1;
        run = 1'b1;
        tick();
        if (fail_cnt == 0) begin
            fd = $fopen("tests/hdc_core_vectors.txt", "r");
            while ($fscanf(fd, "%s", kw) == 1) begin
                if (kw == "#") begin
                    r = $fgets(buf_line, fd);
                end else if (kw == "word") begin
                    r = $fscanf(fd, "%h", a);
                    com = 1'b1;
                    word_valid = 1'b1;
                    word_in = a;
                    host_line[host_slot*32 +: 32] = a;
                    host_slot++;
                    if (host_slot == `HDC_WORDS) begin
                        m_mem[host_addr] = host_line;
                        host_addr++;
                        host_slot = 0;
                    end
                    tick();
                    word_valid = 1'b0;
                    prev_inst = 1'b0;
                end else if (kw == "inst") begin
                    r = $fscanf(fd, "%h %h", a, b);
                    issue(a[15:0], b);
                    prev_inst = 1'b1;
                end else if (kw == "wait") begin
                    r = $fscanf(fd, "%h %h", a, b);
                    com = 1'b0;
                    gen = 1'b0;
                    run = b[0];
                    // an instruction issued just before run drops never executes
                    if (!b[0] && prev_inst) begin
                        m_work = snap_work;
                        m_saved = snap_saved;
                        while (exp_q.size() > snap_size) void'(exp_q.pop_back());
                        exp_last = snap_last;
                    end
                    host_addr = 0;
                    host_slot = 0;
                    repeat (a) tick();
                    prev_inst = 1'b0;
                end else if (kw == "gen") begin
                    r = $fscanf(fd, "%h %h", a, b);
                    reseed = 1'b1;
                    tick();
                    reseed = 1'b0;
                    m_prng = PRNG_SEED;
                    item_count = b[3:0];
                    done_cnt = 0;
                    gen = 1'b1;
                    repeat (4 * a) tick();
                    gen = 1'b0;
                    for (int i = 0; i < a; i++) begin
                        for (int s = 0; s < `HDC_WORDS; s++) begin
                            m_mem[i][s*32 +: 32] = m_prng;
                            m_prng = xorshift(m_prng);
                        end
                    end
                    repeat (3) tick();
                    check_value("gen_done", (b < a) ? 1 : 0, done_cnt);
                    prev_inst = 1'b0;
                end else if (kw == "expect") begin
                    r = $fscanf(fd, "%s %h", name, a);
                    finish_test(name, a);
                    prev_inst = 1'b0;
                end else begin
                    $display("unknown vector command %0s", kw);
                    fail_cnt++;
                end
            end
            $fclose(fd);
        end
        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && pass_cnt > 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- hdc_core_top.f
+incdir+rtl
rtl/hdc_pkg.sv
rtl/hdc_fill_if.sv
rtl/hdc_core_ctrl.sv
rtl/xorshift_prng.sv
rtl/item_line_builder.sv
rtl/item_memory.sv
rtl/hv_alu.sv
rtl/hdc_core_top.sv
tests/hdc_core_properties.sv
tests/hdc_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

out=$(verilator --binary --timing --assert -Wno-fatal \
        -f hdc_core_top.f --top-module hdc_core_tb -o hdc_sim \
    && ./obj_dir/hdc_sim) || { echo "$out"; exit 1; }

echo "$out"
echo "$out" | grep -q "^TEST RESULT: PASS$" && exit 0 || exit 1

//--- tests/hdc_core_vectors.txt
# word <hex32> | inst <hex16> <gap> | gen <lines> <count> | wait <cycles> <run>
# expect <name> <last pulses>
word 0123abcd
word 89ef4567
word deadbeef
word 0f1e2d3c
word a5a5c3c3
word 76543210
word fedcba98
word 13579bdf
wait 2 1
inst 2000 0
inst a000 0
inst 2001 0
inst a000 0
expect host 0
gen 3 2
inst 2000 0
inst a000 0
inst 2001 0
inst a000 0
inst 2002 0
inst a000 0
expect gen 0
inst 2001 0
inst 402c 0
inst a000 0
inst 407f 0
inst a000 0
expect rotate 0
inst 2000 0
inst 8000 0
inst 2002 0
inst 6000 0
inst a000 0
inst 2000 1
inst 8000 1
inst 2002 1
inst 6000 1
inst a000 1
expect bind 0
inst 2001 0
inst c000 0
inst e001 0
expect last 1
inst 2002 0
inst 4005 0
inst a000 0
wait 3 0
wait 2 1
inst a000 0
expect runclr 0
